// File: hdl/div_pkg.sv
`default_nettype none

package div_pkg;

    // ==================================================
    // datapath width
    // ==================================================

    // word ops only make sense on a 64-bit datapath
    localparam int xlen = 64;

    // ==================================================
    // operation encoding
    // ==================================================

    // bit 2 word, bit 1 remainder wanted, bit 0 unsigned
    typedef enum logic [2:0] {
        op_div   = 3'b000,
        op_divu  = 3'b001,
        op_rem   = 3'b010,
        op_remu  = 3'b011,
        op_divw  = 3'b100,
        op_divuw = 3'b101,
        op_remw  = 3'b110,
        op_remuw = 3'b111
    } div_op_e;

    // ==================================================
    // core state machine
    // ==================================================

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_busy = 2'b01,
        st_done = 2'b10
    } div_state_e;

endpackage

`default_nettype wire

// File: hdl/div_operand_if.sv
`timescale 1ns/1ps
`default_nettype none

// prepared operation, decode to core
interface div_operand_if #(
    parameter int TAG_W = 4
) ();

    logic                        valid;
    logic                        ready;
    logic [div_pkg::xlen-1:0]    a_mag;
    logic [div_pkg::xlen-1:0]    b_mag;
    logic                        word;
    logic                        want_rem;
    logic                        q_neg;
    logic                        r_neg;
    logic                        special;
    logic [div_pkg::xlen-1:0]    special_q;
    logic [div_pkg::xlen-1:0]    special_r;
    logic [TAG_W-1:0]            tag;

    modport decode (
        output valid, a_mag, b_mag, word, want_rem, q_neg, r_neg,
        output special, special_q, special_r, tag,
        input  ready
    );

    modport core (
        input  valid, a_mag, b_mag, word, want_rem, q_neg, r_neg,
        input  special, special_q, special_r, tag,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/div_result_if.sv
`timescale 1ns/1ps
`default_nettype none

// raw quotient and remainder, core to fixup
interface div_result_if #(
    parameter int TAG_W = 4
) ();

    logic                        valid;
    logic                        ready;
    logic [div_pkg::xlen-1:0]    quotient;
    logic [div_pkg::xlen-1:0]    remainder;
    logic                        q_neg;
    logic                        r_neg;
    logic                        word;
    logic                        want_rem;
    logic [TAG_W-1:0]            tag;

    modport core (
        output valid, quotient, remainder, q_neg, r_neg, word, want_rem, tag,
        input  ready
    );

    modport fixup (
        input  valid, quotient, remainder, q_neg, r_neg, word, want_rem, tag,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/div_decode.sv
`timescale 1ns/1ps
`default_nettype none

module div_decode #(
    parameter int IN_DEPTH = 4,
    parameter int TAG_W    = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      req_valid,
    input  wire div_pkg::div_op_e          req_op,
    input  wire logic [div_pkg::xlen-1:0]  req_a,
    input  wire logic [div_pkg::xlen-1:0]  req_b,
    input  wire logic [TAG_W-1:0]          req_tag,
    output logic                           req_credit,
    div_operand_if.decode                  operand
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int XL    = div_pkg::xlen;

    div_pkg::div_op_e  op_mem  [IN_DEPTH];
    logic [XL-1:0]     a_mem   [IN_DEPTH];
    logic [XL-1:0]     b_mem   [IN_DEPTH];
    logic [TAG_W-1:0]  tag_mem [IN_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    logic [2:0]        op_bits;
    logic [XL-1:0]     head_a;
    logic [XL-1:0]     head_b;
    logic [XL-1:0]     a_view;
    logic              is_word;
    logic              is_signed;
    logic              a_neg;
    logic              b_neg;
    logic              div_zero;
    logic              overflow;
    logic [XL-1:0]     a_mag;
    logic [XL-1:0]     b_mag;

    // ==================================================
    // request queue
    // ==================================================

    // decode register free or draining this cycle
    assign pop = (count != '0) && (!operand.valid || operand.ready);

    // issuer credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (req_valid) begin
            op_mem[wr_ptr]  <= req_op;
            a_mem[wr_ptr]   <= req_a;
            b_mem[wr_ptr]   <= req_b;
            tag_mem[wr_ptr] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + CNT_W'(req_valid) - CNT_W'(pop);
            // credit goes back with the entry that just left
            req_credit <= pop;
        end
    end

    // ==================================================
    // operand preparation
    // ==================================================

    always_comb begin
        op_bits   = op_mem[rd_ptr];
        head_a    = a_mem[rd_ptr];
        head_b    = b_mem[rd_ptr];
        is_word   = op_bits[2];
        is_signed = !op_bits[0];

        a_neg  = is_signed && (is_word ? head_a[31] : head_a[63]);
        b_neg  = is_signed && (is_word ? head_b[31] : head_b[63]);
        a_view = is_word ? {32'd0, head_a[31:0]} : head_a;

        // magnitudes of the low word for word ops
        a_mag = is_word ? {32'd0, a_neg ? 32'd0 - head_a[31:0] : head_a[31:0]}
                        : (a_neg ? 64'd0 - head_a : head_a);
        b_mag = is_word ? {32'd0, b_neg ? 32'd0 - head_b[31:0] : head_b[31:0]}
                        : (b_neg ? 64'd0 - head_b : head_b);

        div_zero = is_word ? (head_b[31:0] == 32'd0) : (head_b == 64'd0);
        // most negative value over minus one
        overflow = is_signed &&
                   (is_word ? (head_a[31:0] == 32'h8000_0000 && head_b[31:0] == '1)
                            : (head_a == {1'b1, 63'd0} && head_b == '1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            operand.valid <= 1'b0;
        end else if (pop) begin
            operand.valid <= 1'b1;
        end else if (operand.ready) begin
            operand.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            operand.a_mag     <= a_mag;
            operand.b_mag     <= b_mag;
            operand.word      <= is_word;
            operand.want_rem  <= op_bits[1];
            operand.q_neg     <= a_neg ^ b_neg;
            operand.r_neg     <= a_neg;
            operand.special   <= div_zero || overflow;
            operand.special_q <= div_zero ? '1 : a_view;
            operand.special_r <= div_zero ? a_view : '0;
            operand.tag       <= tag_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_core.sv
`timescale 1ns/1ps
`default_nettype none

module div_core #(
    parameter int TAG_W = 4
) (
    input  wire logic  clk,
    input  wire logic  rst,
    div_operand_if.core operand,
    div_result_if.core  result
);

    localparam int XL = div_pkg::xlen;

    div_pkg::div_state_e  state;
    div_pkg::div_state_e  state_nxt;

    logic [XL-1:0]    rem_q;
    logic [2*XL-1:0]  dvs_q;
    logic [XL-1:0]    quo_q;
    logic [6:0]       cnt;
    logic [6:0]       cnt_last;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             word_q;
    logic             want_rem_q;
    logic [TAG_W-1:0] tag_q;

    logic             accept;
    logic [XL-1:0]    step_rem_in;
    logic [2*XL-1:0]  step_dvs_in;
    logic [XL-1:0]    step_quo_in;
    logic             step_ge;
    logic [XL-1:0]    step_rem;
    logic [2*XL-1:0]  step_dvs;
    logic [XL-1:0]    step_quo;

    assign operand.ready = (state == div_pkg::st_idle);
    assign accept        = operand.valid && operand.ready;
    assign cnt_last      = word_q ? 7'd32 : 7'd64;

    // ==================================================
    // one restoring step
    // ==================================================

    // first step runs on the incoming operands during the accept cycle
    always_comb begin
        if (state == div_pkg::st_idle) begin
            step_rem_in = operand.a_mag;
            step_dvs_in = operand.word ? {{(XL / 2 + 1){1'b0}}, operand.b_mag, 31'd0}
                                       : {1'b0, operand.b_mag, 63'd0};
            step_quo_in = '0;
        end else begin
            step_rem_in = rem_q;
            step_dvs_in = dvs_q;
            step_quo_in = quo_q;
        end
        step_ge  = {{XL{1'b0}}, step_rem_in} >= step_dvs_in;
        // divisor fits below 2^64 whenever the subtract happens
        step_rem = step_ge ? step_rem_in - step_dvs_in[XL-1:0] : step_rem_in;
        step_dvs = step_dvs_in >> 1;
        step_quo = {step_quo_in[XL-2:0], step_ge};
    end

    // ==================================================
    // state machine
    // ==================================================

    always_comb begin
        state_nxt = state;
        case (state)
            div_pkg::st_idle: begin
                if (accept) begin
                    state_nxt = operand.special ? div_pkg::st_done : div_pkg::st_busy;
                end
            end
            div_pkg::st_busy: begin
                if (cnt + 7'd1 == cnt_last) begin
                    state_nxt = div_pkg::st_done;
                end
            end
            div_pkg::st_done: begin
                if (result.ready) begin
                    state_nxt = div_pkg::st_idle;
                end
            end
            default: state_nxt = div_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // working registers
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q     <= operand.word;
            want_rem_q <= operand.want_rem;
            tag_q      <= operand.tag;
            cnt        <= 7'd1;
            if (operand.special) begin
                // skip the loop, signs already final
                quo_q   <= operand.special_q;
                rem_q   <= operand.special_r;
                q_neg_q <= 1'b0;
                r_neg_q <= 1'b0;
            end else begin
                quo_q   <= step_quo;
                rem_q   <= step_rem;
                dvs_q   <= step_dvs;
                q_neg_q <= operand.q_neg;
                r_neg_q <= operand.r_neg;
            end
        end else if (state == div_pkg::st_busy) begin
            quo_q <= step_quo;
            rem_q <= step_rem;
            dvs_q <= step_dvs;
            cnt   <= cnt + 7'd1;
        end
    end

    assign result.valid     = (state == div_pkg::st_done);
    assign result.quotient  = quo_q;
    assign result.remainder = rem_q;
    assign result.q_neg     = q_neg_q;
    assign result.r_neg     = r_neg_q;
    assign result.word      = word_q;
    assign result.want_rem  = want_rem_q;
    assign result.tag       = tag_q;

endmodule

`default_nettype wire

// File: hdl/div_fixup.sv
`timescale 1ns/1ps
`default_nettype none

module div_fixup #(
    parameter int OUT_CREDITS = 2,
    parameter int TAG_W       = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      resp_credit,
    div_result_if.fixup                    result,
    output logic                           resp_valid,
    output logic [div_pkg::xlen-1:0]       resp_data,
    output logic [TAG_W-1:0]               resp_tag
);

    localparam int XL    = div_pkg::xlen;
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             out_full;
    logic             fire;
    logic             load;
    logic [XL-1:0]    q_fix;
    logic [XL-1:0]    r_fix;
    logic [XL-1:0]    sel;
    logic [XL-1:0]    data_nxt;
    logic [XL-1:0]    data_q;
    logic [TAG_W-1:0] tag_q;

    // ==================================================
    // sign correction and selection
    // ==================================================

    always_comb begin
        q_fix    = result.q_neg ? XL'(0) - result.quotient : result.quotient;
        r_fix    = result.r_neg ? XL'(0) - result.remainder : result.remainder;
        sel      = result.want_rem ? r_fix : q_fix;
        // word results come back sign-extended from bit 31
        data_nxt = result.word ? {{32{sel[31]}}, sel[31:0]} : sel;
    end

    // ==================================================
    // output register and consumer credits
    // ==================================================

    assign fire         = out_full && (credit_cnt != '0);
    assign result.ready = !out_full || fire;
    assign load         = result.valid && result.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_full   <= 1'b0;
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            if (load) begin
                out_full <= 1'b1;
            end else if (fire) begin
                out_full <= 1'b0;
            end
            credit_cnt <= credit_cnt + CNT_W'(resp_credit) - CNT_W'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= data_nxt;
            tag_q  <= result.tag;
        end
    end

    assign resp_valid = fire;
    assign resp_data  = data_q;
    assign resp_tag   = tag_q;

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2,
    parameter int TAG_W       = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // request side, issuer holds IN_DEPTH credits
    input  wire logic                      req_valid,
    input  wire div_pkg::div_op_e          req_op,
    input  wire logic [div_pkg::xlen-1:0]  req_a,
    input  wire logic [div_pkg::xlen-1:0]  req_b,
    input  wire logic [TAG_W-1:0]          req_tag,
    output logic                           req_credit,

    // response side, consumer returns credits
    output logic                           resp_valid,
    output logic [div_pkg::xlen-1:0]       resp_data,
    output logic [TAG_W-1:0]               resp_tag,
    input  wire logic                      resp_credit
);

    div_operand_if #(.TAG_W(TAG_W)) operand_if ();
    div_result_if  #(.TAG_W(TAG_W)) result_if ();

    div_decode #(
        .IN_DEPTH (IN_DEPTH),
        .TAG_W    (TAG_W)
    ) i_div_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .req_tag    (req_tag),
        .req_credit (req_credit),
        .operand    (operand_if.decode)
    );

    div_core #(
        .TAG_W (TAG_W)
    ) i_div_core (
        .clk     (clk),
        .rst     (rst),
        .operand (operand_if.core),
        .result  (result_if.core)
    );

    div_fixup #(
        .OUT_CREDITS (OUT_CREDITS),
        .TAG_W       (TAG_W)
    ) i_div_fixup (
        .clk         (clk),
        .rst         (rst),
        .resp_credit (resp_credit),
        .result      (result_if.fixup),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_tag    (resp_tag)
    );

endmodule

`default_nettype wire

// File: verification/div_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_assertions #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire logic                                  req_valid,
    input  wire logic                                  resp_valid,
    input  wire logic                                  resp_credit,
    input  wire logic [$clog2(IN_DEPTH + 1)-1:0]       queue_count,
    input  wire logic                                  queue_pop,
    input  wire logic [$clog2(OUT_CREDITS + 1)-1:0]    credit_cnt,
    input  wire logic                                  operand_valid,
    input  wire logic                                  operand_ready,
    input  wire logic                                  operand_special,
    input  wire logic                                  operand_word,
    input  wire logic                                  result_valid
);

    localparam int QCNT_W = $clog2(IN_DEPTH + 1);
    localparam int CCNT_W = $clog2(OUT_CREDITS + 1);

    int resp_credits;

    // consumer credits as seen at the ports
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_credits <= OUT_CREDITS;
        end else begin
            resp_credits <= resp_credits + int'(resp_credit) - int'(resp_valid);
        end
    end

    // ==================================================
    // credit accounting
    // ==================================================

    // a write into a full queue needs an entry leaving in the same cycle
    a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (req_valid && queue_count == QCNT_W'(IN_DEPTH)) |-> queue_pop)
        else $error("request queue overflow");

    a_queue_bound: assert property (@(posedge clk) disable iff (rst)
        queue_count <= QCNT_W'(IN_DEPTH))
        else $error("request queue count above depth");

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CCNT_W'(OUT_CREDITS))
        else $error("output credit count above its initial value");

    a_resp_has_credit: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (resp_credits > 0))
        else $error("response sent without an output credit");

    // ==================================================
    // core handshake
    // ==================================================

    a_core_dword_latency: assert property (@(posedge clk) disable iff (rst)
        (operand_valid && operand_ready && !operand_special && !operand_word)
        |-> ##63 !result_valid ##1 result_valid)
        else $error("doubleword result not valid exactly 64 cycles after accept");

    a_core_word_latency: assert property (@(posedge clk) disable iff (rst)
        (operand_valid && operand_ready && !operand_special && operand_word)
        |-> ##31 !result_valid ##1 result_valid)
        else $error("word result not valid exactly 32 cycles after accept");

endmodule

bind div_unit div_unit_assertions #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) i_div_unit_assertions (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (req_valid),
    .resp_valid      (resp_valid),
    .resp_credit     (resp_credit),
    .queue_count     (i_div_decode.count),
    .queue_pop       (i_div_decode.pop),
    .credit_cnt      (i_div_fixup.credit_cnt),
    .operand_valid   (operand_if.valid),
    .operand_ready   (operand_if.ready),
    .operand_special (operand_if.special),
    .operand_word    (operand_if.word),
    .result_valid    (result_if.valid)
);

`default_nettype wire

// File: verification/div_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

    localparam int IN_DEPTH       = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int TAG_W          = 4;
    localparam int TOTAL_OPS      = 156;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 80 + 2000;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     req_valid;
    div_pkg::div_op_e         req_op;
    logic [63:0]              req_a;
    logic [63:0]              req_b;
    logic [TAG_W-1:0]         req_tag;
    logic                     req_credit;
    logic                     resp_valid;
    logic [63:0]              resp_data;
    logic [TAG_W-1:0]         resp_tag;
    logic                     resp_credit;

    logic [TAG_W-1:0]         exp_tag [$];
    logic [63:0]              exp_data [$];
    logic [31:0]              rng = 32'h2dc84c08;
    logic [31:0]              credit_rng = 32'h2dc84c08;
    string                    current_test = "reset";
    int                       credits = IN_DEPTH;
    int                       sent_count = 0;
    int                       credit_pulses = 0;
    int                       owed = 0;
    int                       credit_delay = 0;
    int                       withheld_resp = 0;
    logic                     withhold = 1'b0;
    int                       errors = 0;
    int                       check_count = 0;
    int                       test_count = 0;
    int                       err_start = 0;
    int                       sent_start = 0;

    div_unit #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .TAG_W       (TAG_W)
    ) i_div_unit (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_a       (req_a),
        .req_b       (req_b),
        .req_tag     (req_tag),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_tag    (resp_tag),
        .resp_credit (resp_credit)
    );

    always #50 clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // RISC-V M rules, division truncates toward zero
    function automatic logic [63:0] div_ref(input div_pkg::div_op_e op,
                                            input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [63:0]        q;
        logic [63:0]        r;
        logic [31:0]        wq;
        logic [31:0]        wr;
        sa = a;
        sb = b;
        wa = a[31:0];
        wb = b[31:0];
        if (op[2]) begin
            if (b[31:0] == 32'd0) begin
                wq = '1;
                wr = a[31:0];
            end else if (op[0]) begin
                wq = a[31:0] / b[31:0];
                wr = a[31:0] % b[31:0];
            end else if (a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
                wq = a[31:0];
                wr = 32'd0;
            end else begin
                wq = wa / wb;
                wr = wa % wb;
            end
            q = {{32{wq[31]}}, wq};
            r = {{32{wr[31]}}, wr};
        end else begin
            if (b == 64'd0) begin
                q = '1;
                r = a;
            end else if (op[0]) begin
                q = a / b;
                r = a % b;
            end else if (a == 64'h8000_0000_0000_0000 && b == '1) begin
                q = a;
                r = 64'd0;
            end else begin
                q = sa / sb;
                r = sa % sb;
            end
        end
        return op[1] ? r : q;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic next_rand64(output logic [63:0] v);
        rng = xorshift32(rng);
        v[63:32] = rng;
        rng = xorshift32(rng);
        v[31:0] = rng;
    endtask

    // one request per cycle while the issuer holds a credit
    task automatic send_req(input div_pkg::div_op_e op, input logic [63:0] a,
                            input logic [63:0] b);
        @(posedge clk);
        #1;
        while (credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req_op    = op;
        req_a     = a;
        req_b     = b;
        req_tag   = TAG_W'(sent_count);
        credits--;
        sent_count++;
        exp_tag.push_back(TAG_W'(sent_count - 1));
        exp_data.push_back(div_ref(op, a, b));
    endtask

    task automatic stop_req();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        current_test = name;
        err_start    = errors;
        sent_start   = sent_count;
    endtask

    // wait for every response and every returned credit
    task automatic finish_test();
        while (exp_data.size() != 0 || owed != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        test_count++;
        $display("%s: %0d ops, %0d errors", current_test, sent_count - sent_start,
                 errors - err_start);
    endtask

    // ==================================================
    // credit models and response checking
    // ==================================================

    always @(negedge clk) begin
        if (!rst && req_credit) begin
            credits++;
            credit_pulses++;
        end
        // every credit must belong to a request already sent
        if (credit_pulses > sent_count) begin
            $display("%0d request credits returned for %0d requests in %s",
                     credit_pulses, sent_count, current_test);
            errors++;
        end
    end

    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            if (exp_data.size() == 0) begin
                $display("response with tag %0d arrived with no request outstanding",
                         resp_tag);
                errors++;
            end else begin
                check_value({current_test, " tag"}, 64'(exp_tag.pop_front()), 64'(resp_tag));
                check_value({current_test, " data"}, exp_data.pop_front(), resp_data);
            end
            if (withhold) begin
                withheld_resp++;
            end
            owed++;
        end
    end

    // consumer hands credits back after a short random delay
    always @(posedge clk) begin
        #1;
        resp_credit = 1'b0;
        if (!rst && !withhold && owed > 0) begin
            if (credit_delay == 0) begin
                resp_credit  = 1'b1;
                owed--;
                credit_rng   = xorshift32(credit_rng);
                credit_delay = int'(credit_rng % 32'd4);
            end else begin
                credit_delay--;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles in %s with %0d responses missing",
                 cycles, current_test, exp_data.size());
        $display("Test failed");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================

    initial begin : main
        logic [63:0]      a;
        logic [63:0]      b;
        logic [63:0]      r;
        div_pkg::div_op_e op;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = div_pkg::op_div;
        req_a       = 64'd0;
        req_b       = 64'd0;
        req_tag     = '0;
        resp_credit = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("unsigned doubleword");
        for (int i = 0; i < 20; i++) begin
            next_rand64(a);
            next_rand64(r);
            b = r >> r[5:0];
            send_req(div_pkg::op_divu, a, b);
            send_req(div_pkg::op_remu, a, b);
        end
        stop_req();
        finish_test();

        start_test("signed doubleword");
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 5; i++) begin
                next_rand64(a);
                a = a >> 1;
                next_rand64(r);
                b = (r >> (r[5:0] | 6'd2)) | 64'd1;
                // sign combination picked by s
                if (s[1]) a = 64'd0 - a;
                if (s[0]) b = 64'd0 - b;
                send_req(div_pkg::op_div, a, b);
                send_req(div_pkg::op_rem, a, b);
            end
        end
        stop_req();
        finish_test();

        start_test("word operations");
        for (int i = 0; i < 10; i++) begin
            next_rand64(a);
            next_rand64(r);
            b = {r[63:32], (r[31:0] >> r[4:0]) | 32'd1};
            send_req(div_pkg::op_divw, a, b);
            send_req(div_pkg::op_divuw, a, b);
            send_req(div_pkg::op_remw, a, b);
            send_req(div_pkg::op_remuw, a, b);
        end
        stop_req();
        finish_test();

        start_test("special cases");
        for (int i = 0; i < 8; i++) begin
            next_rand64(a);
            next_rand64(r);
            // word zero divisors carry garbage above bit 31
            b = (i >= 4) ? {r[63:32], 32'd0} : 64'd0;
            send_req(div_pkg::div_op_e'(3'(i)), a, b);
        end
        a = 64'h8000_0000_0000_0000;
        b = '1;
        send_req(div_pkg::op_div, a, b);
        send_req(div_pkg::op_rem, a, b);
        send_req(div_pkg::op_divu, a, b);
        send_req(div_pkg::op_remu, a, b);
        next_rand64(r);
        a = {r[63:32], 32'h8000_0000};
        b = {r[31:0], 32'hffff_ffff};
        send_req(div_pkg::op_divw, a, b);
        send_req(div_pkg::op_remw, a, b);
        send_req(div_pkg::op_divuw, a, b);
        send_req(div_pkg::op_remuw, a, b);
        stop_req();
        finish_test();

        start_test("input credit burst");
        for (int i = 0; i < 12; i++) begin
            next_rand64(a);
            next_rand64(r);
            b = r >> r[5:0];
            op = div_pkg::div_op_e'(a[2:0]);
            send_req(op, a, b);
        end
        stop_req();
        finish_test();
        check_value({current_test, " credit pulses"}, 64'(sent_count), 64'(credit_pulses));

        start_test("output back-pressure");
        withhold      = 1'b1;
        withheld_resp = 0;
        for (int i = 0; i < 8; i++) begin
            next_rand64(a);
            next_rand64(r);
            b = r >> r[5:0];
            op = div_pkg::div_op_e'({1'b0, a[1:0]});
            send_req(op, a, b);
        end
        stop_req();
        repeat (300) @(posedge clk);
        check_value({current_test, " withheld responses"}, 64'(OUT_CREDITS),
                    64'(withheld_resp));
        withhold = 1'b0;
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hdl/div_pkg.sv
hdl/div_operand_if.sv
hdl/div_result_if.sv
hdl/div_decode.sv
hdl/div_core.sv
hdl/div_fixup.sv
hdl/div_unit.sv
verification/div_unit_assertions.sv
verification/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb \
    -f sim.f \
    -o div_unit_sim

status=0
./obj_dir/div_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
exit 0
